//--- design/cpu_ctrl_consts.svh
`ifndef CPU_CTRL_CONSTS_SVH
`define CPU_CTRL_CONSTS_SVH

// Console switch codes
`define CPU_SW_RUN      3'b000
`define CPU_SW_WR_MEM   3'b001
`define CPU_SW_RD_MEM   3'b010
`define CPU_SW_RD_REG   3'b011
`define CPU_SW_WR_REG   3'b100

// Upper opcode field, 1011 left unused
`define CPU_OP_ADD      4'b0001
`define CPU_OP_SUB      4'b0010
`define CPU_OP_AND      4'b0011
`define CPU_OP_INC      4'b0100
`define CPU_OP_LD       4'b0101
`define CPU_OP_ST       4'b0110
`define CPU_OP_JC       4'b0111
`define CPU_OP_JZ       4'b1000
`define CPU_OP_JMP      4'b1001
`define CPU_OP_OUT      4'b1010
`define CPU_OP_OR       4'b1100
`define CPU_OP_XOR      4'b1101
`define CPU_OP_STP      4'b1110

// ALU S field, used together with M and CIN
`define ALU_FN_ADD      4'b1001
`define ALU_FN_SUB      4'b0110
`define ALU_FN_AND      4'b1011
`define ALU_FN_INC      4'b0000
`define ALU_FN_PASS_A   4'b1010
`define ALU_FN_PASS_B   4'b1111
`define ALU_FN_OR       4'b1110
`define ALU_FN_XOR      4'b0110  // Same code as SUB, M tells them apart

`define REG_SEL_RD_PAIR0 4'b0001 // R0 on A, R1 on B
`define REG_SEL_RD_PAIR1 4'b1011 // R2 on A, R3 on B

`endif

//--- design/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // Console switch code SW[2:0]
    typedef logic [2:0] console_sw_t;

    // Upper four instruction register bits
    typedef logic [3:0] opcode_t;

    // ALU function select S[3:0]
    typedef logic [3:0] alu_fn_t;

    // Register file select, {A select, B select}
    typedef logic [3:0] reg_sel_t;

    // Machine beat lines
    // bit 0 is W1, bit 1 is W2, bit 2 is W3
    typedef logic [2:0] beat_t;

    // Console operation pass
    typedef enum logic {
        PHASE_SETUP = 1'b0,  // Address or first register pair
        PHASE_RUN   = 1'b1   // Data transfer pass
    } phase_t;

endpackage

//--- design/ctrl_word_if.sv
interface ctrl_word_if;

    logic ldc;       // Load carry flag
    logic ldz;       // Load zero flag
    logic cin;
    logic m;         // ALU logic mode
    logic abus;      // ALU onto data bus
    logic drw;       // Register file write
    logic pcinc;
    logic lpc;
    logic lar;
    logic pcadd;
    logic arinc;
    logic selctl;    // Console drives register select
    logic memw;
    logic stop;
    logic lir;
    logic sbus;      // Switches onto data bus
    logic mbus;      // Memory onto data bus
    logic short_cyc; // Skip W2
    logic long_cyc;  // Add W3
    cpu_ctrl_pkg::alu_fn_t  s;
    cpu_ctrl_pkg::reg_sel_t sel;

    modport src (
        output ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc,
        output selctl, memw, stop, lir, sbus, mbus, short_cyc, long_cyc,
        output s, sel
    );

    modport sink (
        input ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc,
        input selctl, memw, stop, lir, sbus, mbus, short_cyc, long_cyc,
        input s, sel
    );

endinterface

//--- design/console_seq.sv
`include "cpu_ctrl_consts.svh"

module console_seq (
    input  logic                     t3,
    input  logic                     rst_n,
    input  cpu_ctrl_pkg::console_sw_t sw,
    input  cpu_ctrl_pkg::beat_t       w,
    ctrl_word_if.src                 con_word,
    output logic                     run_mode
);

    cpu_ctrl_pkg::phase_t phase;
    logic                 set_run;
    logic                 in_setup;
    logic                 in_run;

    assign in_setup = (phase == cpu_ctrl_pkg::PHASE_SETUP);
    assign in_run   = (phase == cpu_ctrl_pkg::PHASE_RUN);

    assign run_mode = rst_n && (sw == `CPU_SW_RUN);

    // Phase moves on the falling edge of t3, set has priority
    always_ff @(negedge t3 or negedge rst_n) begin
        if (!rst_n) begin
            phase <= cpu_ctrl_pkg::PHASE_SETUP;
        end else if (set_run) begin
            phase <= cpu_ctrl_pkg::PHASE_RUN;
        end else if (sw == `CPU_SW_WR_REG && in_run && w[1]) begin
            phase <= cpu_ctrl_pkg::PHASE_SETUP;
        end
    end

    always_comb begin
        set_run            = 1'b0;
        con_word.ldc       = 1'b0;
        con_word.ldz       = 1'b0;
        con_word.cin       = 1'b0;
        con_word.m         = 1'b0;
        con_word.abus      = 1'b0;
        con_word.drw       = 1'b0;
        con_word.pcinc     = 1'b0;
        con_word.lpc       = 1'b0;
        con_word.lar       = 1'b0;
        con_word.pcadd     = 1'b0;
        con_word.arinc     = 1'b0;
        con_word.selctl    = 1'b0;
        con_word.memw      = 1'b0;
        con_word.stop      = 1'b0;
        con_word.lir       = 1'b0;
        con_word.sbus      = 1'b0;
        con_word.mbus      = 1'b0;
        con_word.short_cyc = 1'b0;
        con_word.long_cyc  = 1'b0;
        con_word.s         = '0;
        con_word.sel       = '0;

        if (rst_n) begin
            case (sw)
                `CPU_SW_WR_MEM: begin
                    con_word.lar       = w[0] && in_setup; // Address first
                    con_word.memw      = w[0] && in_run;
                    con_word.arinc     = w[0] && in_run;
                    con_word.sbus      = w[0];
                    con_word.stop      = w[0];
                    con_word.short_cyc = w[0];
                    con_word.selctl    = w[0];
                    set_run            = w[0];
                end
                `CPU_SW_RD_MEM: begin
                    con_word.sbus      = w[0] && in_setup;
                    con_word.lar       = w[0] && in_setup;
                    set_run            = w[0] && in_setup;
                    con_word.mbus      = w[0] && in_run;
                    con_word.arinc     = w[0] && in_run;
                    con_word.stop      = w[0];
                    con_word.short_cyc = w[0];
                    con_word.selctl    = w[0];
                end
                `CPU_SW_RD_REG: begin
                    con_word.selctl = w[0] || w[1];
                    con_word.stop   = w[0] || w[1];
                    if (w[1]) begin
                        con_word.sel = `REG_SEL_RD_PAIR1;
                    end else if (w[0]) begin
                        con_word.sel = `REG_SEL_RD_PAIR0;
                    end
                end
                `CPU_SW_WR_REG: begin
                    con_word.sbus   = w[0] || w[1];
                    con_word.selctl = w[0] || w[1];
                    con_word.drw    = w[0] || w[1];
                    con_word.stop   = w[0] || w[1];
                    set_run         = w[1] && in_setup;
                    // R0,R1 in setup, R2,R3 in run
                    con_word.sel[3] = in_run;
                    con_word.sel[2] = w[1];
                    con_word.sel[1] = in_setup ? w[0] : w[1];
                    con_word.sel[0] = w[0];
                end
                default: begin
                    set_run = 1'b0; // Run mode is the decoder's
                end
            endcase
        end
    end

endmodule

//--- design/instr_decoder.sv
`include "cpu_ctrl_consts.svh"

module instr_decoder (
    input  logic                  run_mode,
    input  cpu_ctrl_pkg::opcode_t ir,
    input  logic                  c,
    input  logic                  z,
    input  cpu_ctrl_pkg::beat_t   w,
    ctrl_word_if.src              run_word
);

    always_comb begin
        run_word.ldc       = 1'b0;
        run_word.ldz       = 1'b0;
        run_word.cin       = 1'b0;
        run_word.m         = 1'b0;
        run_word.abus      = 1'b0;
        run_word.drw       = 1'b0;
        run_word.pcinc     = 1'b0;
        run_word.lpc       = 1'b0;
        run_word.lar       = 1'b0;
        run_word.pcadd     = 1'b0;
        run_word.arinc     = 1'b0;
        run_word.selctl    = 1'b0;
        run_word.memw      = 1'b0;
        run_word.stop      = 1'b0;
        run_word.lir       = 1'b0;
        run_word.sbus      = 1'b0;
        run_word.mbus      = 1'b0;
        run_word.short_cyc = 1'b0;
        run_word.long_cyc  = 1'b0;
        run_word.s         = '0;
        run_word.sel       = '0;

        if (run_mode) begin
            // Fetch on W1
            run_word.lir   = w[0];
            run_word.pcinc = w[0];

            case (ir)
                `CPU_OP_ADD: begin
                    run_word.s    = `ALU_FN_ADD;
                    run_word.cin  = w[1];
                    run_word.abus = w[1];
                    run_word.drw  = w[1];
                    run_word.ldz  = w[1];
                    run_word.ldc  = w[1];
                end
                `CPU_OP_SUB: begin
                    run_word.s    = `ALU_FN_SUB;
                    run_word.abus = w[1];
                    run_word.drw  = w[1];
                    run_word.ldz  = w[1];
                    run_word.ldc  = w[1];
                end
                `CPU_OP_AND: begin
                    run_word.s    = `ALU_FN_AND;
                    run_word.m    = w[1];
                    run_word.abus = w[1];
                    run_word.drw  = w[1];
                    run_word.ldz  = w[1];
                end
                `CPU_OP_INC: begin
                    run_word.s    = `ALU_FN_INC;
                    run_word.abus = w[1];
                    run_word.drw  = w[1];
                    run_word.ldz  = w[1];
                    run_word.ldc  = w[1];
                end
                `CPU_OP_LD: begin
                    run_word.s        = `ALU_FN_PASS_A;
                    run_word.m        = w[1];
                    run_word.abus     = w[1];
                    run_word.lar      = w[1]; // Address from A
                    run_word.long_cyc = w[1];
                    run_word.drw      = w[2];
                    run_word.mbus     = w[2];
                end
                `CPU_OP_ST: begin
                    // B is the address on W2, A is the data on W3
                    run_word.s        = w[1] ? `ALU_FN_PASS_B : `ALU_FN_PASS_A;
                    run_word.m        = w[1] || w[2];
                    run_word.abus     = w[1] || w[2];
                    run_word.lar      = w[1];
                    run_word.long_cyc = w[1];
                    run_word.memw     = w[2];
                end
                `CPU_OP_JC: begin
                    run_word.pcadd = w[1] && c;
                end
                `CPU_OP_JZ: begin
                    run_word.pcadd = w[1] && z;
                end
                `CPU_OP_JMP: begin
                    run_word.s    = `ALU_FN_PASS_B;
                    run_word.m    = w[1];
                    run_word.abus = w[1];
                    run_word.lpc  = w[1];
                end
                `CPU_OP_OUT: begin
                    run_word.s    = `ALU_FN_PASS_A;
                    run_word.m    = w[1];
                    run_word.abus = w[1];
                end
                `CPU_OP_OR: begin
                    run_word.s    = `ALU_FN_OR;
                    run_word.m    = w[1];
                    run_word.abus = w[1];
                    run_word.drw  = w[1];
                    run_word.ldz  = w[1];
                end
                `CPU_OP_XOR: begin
                    run_word.s    = `ALU_FN_XOR;
                    run_word.m    = w[1];
                    run_word.abus = w[1];
                    run_word.drw  = w[1];
                    run_word.ldz  = w[1];
                end
                `CPU_OP_STP: begin
                    run_word.stop = w[1];
                end
                default: begin
                    run_word.s = '0; // NOP and unused codes
                end
            endcase
        end
    end

endmodule

//--- design/cpu_ctrl.sv
module cpu_ctrl (
    input  logic                      t3,
    input  logic                      rst_n,
    input  logic                      c,
    input  logic                      z,
    input  cpu_ctrl_pkg::console_sw_t sw,
    input  cpu_ctrl_pkg::opcode_t     ir,
    input  cpu_ctrl_pkg::beat_t       w,
    output logic                      ldc,
    output logic                      ldz,
    output logic                      cin,
    output logic                      m,
    output logic                      abus,
    output logic                      drw,
    output logic                      pcinc,
    output logic                      lpc,
    output logic                      lar,
    output logic                      pcadd,
    output logic                      arinc,
    output logic                      selctl,
    output logic                      memw,
    output logic                      stop,
    output logic                      lir,
    output logic                      sbus,
    output logic                      mbus,
    output logic                      short_cyc,
    output logic                      long_cyc,
    output cpu_ctrl_pkg::alu_fn_t     s,
    output cpu_ctrl_pkg::reg_sel_t    sel
);

    logic run_mode;

    ctrl_word_if con_word ();
    ctrl_word_if run_word ();

    console_seq u_console (
        .t3       (t3),
        .rst_n    (rst_n),
        .sw       (sw),
        .w        (w),
        .con_word (con_word.src),
        .run_mode (run_mode)
    );

    instr_decoder u_decoder (
        .run_mode (run_mode),
        .ir       (ir),
        .c        (c),
        .z        (z),
        .w        (w),
        .run_word (run_word.src)
    );

    // Only one word is active at a time
    assign ldc       = con_word.ldc       | run_word.ldc;
    assign ldz       = con_word.ldz       | run_word.ldz;
    assign cin       = con_word.cin       | run_word.cin;
    assign m         = con_word.m         | run_word.m;
    assign abus      = con_word.abus      | run_word.abus;
    assign drw       = con_word.drw       | run_word.drw;
    assign pcinc     = con_word.pcinc     | run_word.pcinc;
    assign lpc       = con_word.lpc       | run_word.lpc;
    assign lar       = con_word.lar       | run_word.lar;
    assign pcadd     = con_word.pcadd     | run_word.pcadd;
    assign arinc     = con_word.arinc     | run_word.arinc;
    assign selctl    = con_word.selctl    | run_word.selctl;
    assign memw      = con_word.memw      | run_word.memw;
    assign stop      = con_word.stop      | run_word.stop;
    assign lir       = con_word.lir       | run_word.lir;
    assign sbus      = con_word.sbus      | run_word.sbus;
    assign mbus      = con_word.mbus      | run_word.mbus;
    assign short_cyc = con_word.short_cyc | run_word.short_cyc;
    assign long_cyc  = con_word.long_cyc  | run_word.long_cyc;
    assign s         = con_word.s         | run_word.s;
    assign sel       = con_word.sel       | run_word.sel;

endmodule

//--- testbench/tb_cpu_ctrl.sv
`include "cpu_ctrl_consts.svh"

module tb_cpu_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 8;
    localparam int WATCHDOG_CYCLES = 600;

    // Same field order as the DUT output ports
    typedef struct packed {
        logic ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd;
        logic arinc, selctl, memw, stop, lir, sbus, mbus, short_cyc, long_cyc;
        logic [3:0] s;
        logic [3:0] sel;
    } word_t;

    logic t3, rst_n, c, z;
    cpu_ctrl_pkg::console_sw_t sw;
    cpu_ctrl_pkg::opcode_t     ir;
    cpu_ctrl_pkg::beat_t       w;
    logic ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd;
    logic arinc, selctl, memw, stop, lir, sbus, mbus, short_cyc, long_cyc;
    cpu_ctrl_pkg::alu_fn_t  s;
    cpu_ctrl_pkg::reg_sel_t sel;

    word_t                act_word;
    cpu_ctrl_pkg::phase_t ref_phase;
    integer               seed;
    string                test_name;

    assign act_word = {ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc,
                       selctl, memw, stop, lir, sbus, mbus, short_cyc, long_cyc, s, sel};

    cpu_ctrl uut (
        .t3(t3), .rst_n(rst_n), .c(c), .z(z), .sw(sw), .ir(ir), .w(w),
        .ldc(ldc), .ldz(ldz), .cin(cin), .m(m), .abus(abus), .drw(drw),
        .pcinc(pcinc), .lpc(lpc), .lar(lar), .pcadd(pcadd), .arinc(arinc),
        .selctl(selctl), .memw(memw), .stop(stop), .lir(lir), .sbus(sbus),
        .mbus(mbus), .short_cyc(short_cyc), .long_cyc(long_cyc), .s(s), .sel(sel)
    );

    initial t3 = 1'b0;
    always #(CLK_PERIOD / 2) t3 = ~t3;

    function automatic logic set_run_rule(input logic [2:0] sw_v, input logic [2:0] w_v,
                                          input cpu_ctrl_pkg::phase_t ph_v);
        case (sw_v)
            `CPU_SW_WR_MEM: return w_v[0];
            `CPU_SW_RD_MEM: return w_v[0] && ph_v == cpu_ctrl_pkg::PHASE_SETUP;
            `CPU_SW_WR_REG: return w_v[1] && ph_v == cpu_ctrl_pkg::PHASE_SETUP;
            default:        return 1'b0;
        endcase
    endfunction

    // Reference phase, moves on the falling edge like the console register
    always @(negedge t3 or negedge rst_n) begin
        if (!rst_n) begin
            ref_phase <= cpu_ctrl_pkg::PHASE_SETUP;
        end else if (set_run_rule(sw, w, ref_phase)) begin
            ref_phase <= cpu_ctrl_pkg::PHASE_RUN;
        end else if (sw == `CPU_SW_WR_REG && ref_phase == cpu_ctrl_pkg::PHASE_RUN && w[1]) begin
            ref_phase <= cpu_ctrl_pkg::PHASE_SETUP;
        end
    end

    function automatic word_t expected_word(input logic rst_v, input logic [2:0] sw_v,
                                            input logic [3:0] ir_v, input logic [2:0] w_v,
                                            input logic c_v, input logic z_v,
                                            input cpu_ctrl_pkg::phase_t ph_v);
        word_t e;
        logic  w1, w2, w3, run;
        e   = '0;
        w1  = w_v[0];
        w2  = w_v[1];
        w3  = w_v[2];
        run = (ph_v == cpu_ctrl_pkg::PHASE_RUN);
        if (!rst_v) return e;
        case (sw_v)
            `CPU_SW_RUN: begin
                e.lir   = w1;
                e.pcinc = w1;
                case (ir_v)
                    `CPU_OP_ADD: begin
                        e.s = `ALU_FN_ADD;
                        {e.cin, e.abus, e.drw, e.ldz, e.ldc} = {5{w2}};
                    end
                    `CPU_OP_SUB: begin
                        e.s = `ALU_FN_SUB;
                        {e.abus, e.drw, e.ldz, e.ldc} = {4{w2}};
                    end
                    `CPU_OP_AND: begin
                        e.s = `ALU_FN_AND;
                        {e.m, e.abus, e.drw, e.ldz} = {4{w2}};
                    end
                    `CPU_OP_INC: begin
                        e.s = `ALU_FN_INC;
                        {e.abus, e.drw, e.ldz, e.ldc} = {4{w2}};
                    end
                    `CPU_OP_LD: begin
                        e.s = `ALU_FN_PASS_A;
                        {e.m, e.abus, e.lar, e.long_cyc} = {4{w2}};
                        {e.drw, e.mbus} = {2{w3}};
                    end
                    `CPU_OP_ST: begin
                        e.s          = w2 ? `ALU_FN_PASS_B : `ALU_FN_PASS_A;
                        {e.m, e.abus} = {2{w2 | w3}};
                        {e.lar, e.long_cyc} = {2{w2}};
                        e.memw       = w3;
                    end
                    `CPU_OP_JC:  e.pcadd = w2 & c_v;
                    `CPU_OP_JZ:  e.pcadd = w2 & z_v;
                    `CPU_OP_JMP: begin
                        e.s = `ALU_FN_PASS_B;
                        {e.m, e.abus, e.lpc} = {3{w2}};
                    end
                    `CPU_OP_OUT: begin
                        e.s = `ALU_FN_PASS_A;
                        {e.m, e.abus} = {2{w2}};
                    end
                    `CPU_OP_OR: begin
                        e.s = `ALU_FN_OR;
                        {e.m, e.abus, e.drw, e.ldz} = {4{w2}};
                    end
                    `CPU_OP_XOR: begin
                        e.s = `ALU_FN_XOR;
                        {e.m, e.abus, e.drw, e.ldz} = {4{w2}};
                    end
                    `CPU_OP_STP: e.stop = w2;
                    default: ;
                endcase
            end
            `CPU_SW_WR_MEM: begin
                e.lar = w1 & ~run;
                {e.memw, e.arinc} = {2{w1 & run}};
                {e.sbus, e.stop, e.short_cyc, e.selctl} = {4{w1}};
            end
            `CPU_SW_RD_MEM: begin
                {e.sbus, e.lar}   = {2{w1 & ~run}};
                {e.mbus, e.arinc} = {2{w1 & run}};
                {e.stop, e.short_cyc, e.selctl} = {3{w1}};
            end
            `CPU_SW_RD_REG: begin
                {e.selctl, e.stop} = {2{w1 | w2}};
                e.sel = w2 ? 4'b1011 : (w1 ? 4'b0001 : 4'b0000);
            end
            `CPU_SW_WR_REG: begin
                {e.sbus, e.selctl, e.drw, e.stop} = {4{w1 | w2}};
                e.sel = {run, w2, run ? w2 : w1, w1};
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // One beat of stimulus, word checked mid high phase of t3
    task automatic drive_step(input logic [2:0] sw_v, input logic [3:0] ir_v,
                              input logic [2:0] w_v, input logic c_v, input logic z_v);
        @(posedge t3);
        sw <= sw_v;
        ir <= ir_v;
        w  <= w_v;
        c  <= c_v;
        z  <= z_v;
        #2;
        check_val(test_name, expected_word(rst_n, sw, ir, w, c, z, ref_phase), act_word);
    endtask

    task automatic reset_dut();
        @(posedge t3);
        rst_n <= 1'b0;
        w     <= '0;
        repeat (2) @(posedge t3);
        rst_n <= 1'b1;
    endtask

    task automatic reset_idle();
        test_name = "reset_idle";
        @(posedge t3);
        rst_n <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                drive_step(i, $random(seed), j, $random(seed), $random(seed));
                check_val(test_name, 0, act_word);
            end
        end
        @(posedge t3);
        rst_n <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            drive_step(i, 4'b0000, 3'b000, 1'b0, 1'b0); // NOP keeps s at zero
            check_val(test_name, 0, act_word);
        end
    endtask

    task automatic write_memory();
        test_name = "write_memory";
        reset_dut();
        drive_step(`CPU_SW_WR_MEM, 4'b0000, 3'b001, 1'b0, 1'b0);
        check_val({test_name, " setup lar"}, 1, lar);
        check_val({test_name, " setup memw"}, 0, memw);
        drive_step(`CPU_SW_WR_MEM, 4'b0000, 3'b000, 1'b0, 1'b0);
        repeat (2) begin
            drive_step(`CPU_SW_WR_MEM, 4'b0000, 3'b001, 1'b0, 1'b0);
            check_val({test_name, " run memw"}, 1, memw);
            check_val({test_name, " run lar"}, 0, lar);
        end
    endtask

    task automatic read_memory();
        test_name = "read_memory";
        reset_dut();
        drive_step(`CPU_SW_RD_MEM, 4'b0000, 3'b001, 1'b0, 1'b0);
        check_val({test_name, " setup sbus lar mbus arinc"}, 4'b1100,
                  {sbus, lar, mbus, arinc});
        repeat (2) begin
            drive_step(`CPU_SW_RD_MEM, 4'b0000, 3'b001, 1'b0, 1'b0);
            check_val({test_name, " run sbus lar mbus arinc"}, 4'b0011,
                      {sbus, lar, mbus, arinc});
        end
    endtask

    task automatic register_console();
        test_name = "register_console";
        reset_dut();
        drive_step(`CPU_SW_RD_REG, 4'b0000, 3'b001, 1'b0, 1'b0);
        check_val({test_name, " read sel W1"}, 4'b0001, sel);
        drive_step(`CPU_SW_RD_REG, 4'b0000, 3'b010, 1'b0, 1'b0);
        check_val({test_name, " read sel W2"}, 4'b1011, sel);
        drive_step(`CPU_SW_WR_REG, 4'b0000, 3'b001, 1'b0, 1'b0);
        check_val({test_name, " setup sel W1"}, 4'b0011, sel);
        drive_step(`CPU_SW_WR_REG, 4'b0000, 3'b010, 1'b0, 1'b0);
        check_val({test_name, " setup sel W2"}, 4'b0100, sel);
        drive_step(`CPU_SW_WR_REG, 4'b0000, 3'b001, 1'b0, 1'b0);
        check_val({test_name, " run sel W1"}, 4'b1001, sel);
        drive_step(`CPU_SW_WR_REG, 4'b0000, 3'b010, 1'b0, 1'b0);
        check_val({test_name, " run sel W2"}, 4'b1110, sel);
        // Back in setup after the run pass
        drive_step(`CPU_SW_WR_REG, 4'b0000, 3'b001, 1'b0, 1'b0);
        check_val({test_name, " second setup sel W1"}, 4'b0011, sel);
    endtask

    task automatic instruction_decode();
        test_name = "instruction_decode";
        reset_dut();
        for (int op = 0; op < 16; op++) begin
            for (int b = 0; b < 3; b++) begin
                drive_step(`CPU_SW_RUN, op, 3'b001 << b, $random(seed), $random(seed));
            end
        end
        for (int f = 0; f < 2; f++) begin
            for (int b = 0; b < 3; b++) begin
                drive_step(`CPU_SW_RUN, `CPU_OP_JC, 3'b001 << b, f, !f);
                check_val({test_name, " JC pcadd"}, (b == 1) && (f == 1), pcadd);
                drive_step(`CPU_SW_RUN, `CPU_OP_JZ, 3'b001 << b, !f, f);
                check_val({test_name, " JZ pcadd"}, (b == 1) && (f == 1), pcadd);
            end
        end
    endtask

    task automatic mode_isolation();
        logic [2:0] con_codes [4];
        int         k;
        con_codes = '{`CPU_SW_WR_MEM, `CPU_SW_RD_MEM, `CPU_SW_RD_REG, `CPU_SW_WR_REG};
        test_name = "mode_isolation";
        reset_dut();
        drive_step(`CPU_SW_WR_MEM, 4'b0000, 3'b001, 1'b0, 1'b0);
        drive_step(`CPU_SW_WR_MEM, 4'b0000, 3'b001, 1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            k = {$random(seed)} % 3;
            drive_step(`CPU_SW_RUN, $random(seed), 3'b001 << k, $random(seed), $random(seed));
            check_val({test_name, " console fields in run"}, 0, {selctl, sbus, short_cyc});
        end
        for (int i = 0; i < 12; i++) begin
            k = {$random(seed)} % 3;
            drive_step(con_codes[i % 4], $random(seed), 3'b001 << k, $random(seed),
                       $random(seed));
            check_val({test_name, " decoder fields in console"}, 0,
                      {lir, pcinc, ldc, ldz, cin, lpc, pcadd, s});
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d clock periods", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed      = 32'h0e78_7061;
        test_name = "startup";
        rst_n     = 1'b0;
        sw        = '0;
        ir        = '0;
        w         = '0;
        c         = 1'b0;
        z         = 1'b0;
        repeat (8) @(posedge t3);
        rst_n <= 1'b1;

        reset_idle();
        write_memory();
        read_memory();
        register_console();
        instruction_decode();
        mode_isolation();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+design
design/cpu_ctrl_pkg.sv
design/ctrl_word_if.sv
design/console_seq.sv
design/instr_decoder.sv
design/cpu_ctrl.sv
testbench/tb_cpu_ctrl.sv
